// ==== msx_setup_pkg.sv ====
package msx_setup_pkg;

    typedef logic [63:0] status_t;
    typedef logic [2:0]  cart_type_t;
    typedef logic [5:0]  mapper_t;
    typedef logic [3:0]  mapper_sel_t;
    typedef logic [2:0]  sram_size_t;
    typedef logic [1:0]  video_mode_t;
    typedef logic [1:0]  ram_size_t;
    typedef logic [1:0]  sdram_size_t;
    typedef logic        msx_typ_t;

    localparam msx_typ_t MSX1 = 1'b0;
    localparam msx_typ_t MSX2 = 1'b1;

    localparam cart_type_t CART_TYPE_ROM      = 3'd0;
    localparam cart_type_t CART_TYPE_SCC      = 3'd1;
    localparam cart_type_t CART_TYPE_SCC_PLUS = 3'd2;
    localparam cart_type_t CART_TYPE_FM_PAC   = 3'd3;
    localparam cart_type_t CART_TYPE_GM2      = 3'd4;
    localparam cart_type_t CART_TYPE_FDC      = 3'd5;
    localparam cart_type_t CART_TYPE_EMPTY    = 3'd7;

    // menu choices that do not map one to one onto a result code.
    localparam mapper_sel_t MAPPER_SEL_AUTO = 4'd0;
    localparam mapper_sel_t MAPPER_SEL_NONE = 4'd9;
    localparam sram_size_t  SRAM_SEL_AUTO   = 3'd0;
    localparam sram_size_t  SRAM_SEL_NONE   = 3'd7;

    localparam mapper_t    MAPPER_NO_UNKNOWN = 6'd63;
    localparam ram_size_t  SIZE64            = 2'd1;
    localparam sram_size_t SRAM_SIZE_NONE    = 3'd0;
    localparam sram_size_t SRAM_SIZE_8K      = 3'd4;

    localparam int PIPE_DEPTH = 3;

    typedef logic [$clog2(PIPE_DEPTH)-1:0] settle_cnt_t;
    localparam settle_cnt_t SETTLE_LAST = settle_cnt_t'(PIPE_DEPTH - 1);

    typedef struct packed {
        msx_typ_t    typ;
        logic        scandoubler;
        video_mode_t video_mode;
        logic        cas_audio_src;
        ram_size_t   ram_size;
        logic        border;
    } msx_config_t;

    typedef struct packed {
        cart_type_t  cart_type_a;
        cart_type_t  cart_type_b;
        mapper_sel_t mapper_a_sel;
        mapper_sel_t mapper_b_sel;
        sram_size_t  sram_a_sel;
        logic        eject;
        mapper_t     mapper_detected_a;
        mapper_t     mapper_detected_b;
        sram_size_t  sram_detected_a;
        sram_size_t  sram_detected_b;
        sdram_size_t sdram_size;
        msx_config_t conf;
    } slot_stage_t;

    typedef struct packed {
        cart_type_t  cart_type_a;
        cart_type_t  cart_type_b;
        mapper_t     mapper_a;
        mapper_t     mapper_b;
        sram_size_t  sram_size_a;
        sram_size_t  sram_size_b;
        logic        sram_a_select_hide;
        logic        sram_loadsave_hide;
        logic        rom_a_load_hide;
        logic        rom_b_load_hide;
        logic        fdc_enabled;
        logic        eject;
        mapper_sel_t mapper_a_sel;
        mapper_sel_t mapper_b_sel;
        sram_size_t  sram_a_sel;
        msx_config_t conf;
    } media_stage_t;

endpackage

// ==== slot_resolve.sv ====
`timescale 1ns/1ps

module slot_resolve (
    input  logic                       clk,
    input  logic                       reset,
    input  msx_setup_pkg::status_t     status,
    input  logic                       scandoubler,
    input  msx_setup_pkg::mapper_t     mapper_detected_a,
    input  msx_setup_pkg::mapper_t     mapper_detected_b,
    input  msx_setup_pkg::sram_size_t  sram_detected_a,
    input  msx_setup_pkg::sram_size_t  sram_detected_b,
    input  msx_setup_pkg::sdram_size_t sdram_size,
    output msx_setup_pkg::slot_stage_t slot_q
);
    import msx_setup_pkg::*;

    cart_type_t  slot_a_sel;
    cart_type_t  slot_b_sel;
    cart_type_t  cart_a;
    cart_type_t  cart_b;
    msx_config_t conf;
    slot_stage_t slot_n;

    // slot selects share the cartridge type code for their low entries.
    assign slot_a_sel = status[19:17];
    assign slot_b_sel = status[31:29];

    assign conf.typ           = msx_typ_t'(status[11]);
    assign conf.scandoubler   = scandoubler;
    // an MSX1 only offers two video modes on a single menu bit.
    assign conf.video_mode    = (msx_typ_t'(status[11]) == MSX1) ? (status[12] ? 2'd2 : 2'd1)
                                                                 : video_mode_t'(status[14:13]);
    assign conf.cas_audio_src = status[8];
    assign conf.ram_size      = (sdram_size == 2'd0) ? SIZE64 : ram_size_t'(status[16:15]);
    assign conf.border        = status[38];

    // the FDC entry of slot A is only offered on an MSX1.
    always_comb begin
        if (slot_a_sel < CART_TYPE_FDC) begin
            cart_a = slot_a_sel;
        end else if (conf.typ == MSX1 && slot_a_sel == CART_TYPE_FDC) begin
            cart_a = CART_TYPE_FDC;
        end else begin
            cart_a = CART_TYPE_EMPTY;
        end
    end

    assign cart_b = (slot_b_sel < CART_TYPE_GM2) ? slot_b_sel : CART_TYPE_EMPTY;

    assign slot_n.cart_type_a       = cart_a;
    assign slot_n.cart_type_b       = cart_b;
    assign slot_n.mapper_a_sel      = mapper_sel_t'(status[23:20]);
    assign slot_n.mapper_b_sel      = mapper_sel_t'(status[34:32]);
    assign slot_n.sram_a_sel        = sram_size_t'(status[28:26]);
    assign slot_n.eject             = status[10];
    assign slot_n.mapper_detected_a = mapper_detected_a;
    assign slot_n.mapper_detected_b = mapper_detected_b;
    assign slot_n.sram_detected_a   = sram_detected_a;
    assign slot_n.sram_detected_b   = sram_detected_b;
    assign slot_n.sdram_size        = sdram_size;
    assign slot_n.conf              = conf;

    // a stale eject must not walk into the pipeline while the machine is held.
    always_ff @(posedge clk) begin
        slot_q <= slot_n;
        if (reset) begin
            slot_q.eject <= 1'b0;
        end
    end

endmodule

// ==== media_resolve.sv ====
`timescale 1ns/1ps

module media_resolve (
    input  logic                        clk,
    input  msx_setup_pkg::slot_stage_t  slot_d,
    output msx_setup_pkg::media_stage_t media_q
);
    import msx_setup_pkg::*;

    mapper_t      mapper_a;
    mapper_t      mapper_b;
    sram_size_t   sram_a;
    sram_size_t   sram_b;
    logic         sram_a_hide;
    logic         slot_a_rom;
    logic         slot_b_rom;
    media_stage_t media_n;

    assign slot_a_rom = (slot_d.cart_type_a == CART_TYPE_ROM);
    assign slot_b_rom = (slot_d.cart_type_b == CART_TYPE_ROM);

    assign mapper_a = (slot_d.mapper_a_sel == MAPPER_SEL_AUTO) ? slot_d.mapper_detected_a :
                      (slot_d.mapper_a_sel == MAPPER_SEL_NONE) ? MAPPER_NO_UNKNOWN :
                                                                 mapper_t'(slot_d.mapper_a_sel);

    assign mapper_b = (slot_d.mapper_b_sel == MAPPER_SEL_AUTO) ? slot_d.mapper_detected_b :
                      (slot_d.mapper_b_sel == MAPPER_SEL_NONE) ? MAPPER_NO_UNKNOWN :
                                                                 mapper_t'(slot_d.mapper_b_sel);

    // with auto mapper detection the detector also owns the SRAM size.
    assign sram_a_hide = !slot_a_rom || (slot_d.mapper_a_sel == MAPPER_SEL_AUTO);

    always_comb begin
        if (slot_d.cart_type_a == CART_TYPE_FM_PAC || slot_d.cart_type_a == CART_TYPE_GM2) begin
            sram_a = SRAM_SIZE_8K;
        end else if (slot_d.sram_a_sel == SRAM_SEL_NONE) begin
            sram_a = SRAM_SIZE_NONE;
        end else if (sram_a_hide || slot_d.sram_a_sel == SRAM_SEL_AUTO) begin
            sram_a = slot_d.sram_detected_a;
        end else begin
            sram_a = slot_d.sram_a_sel;
        end
    end

    assign sram_b = (slot_d.cart_type_b == CART_TYPE_FM_PAC) ? SRAM_SIZE_8K : SRAM_SIZE_NONE;

    assign media_n.cart_type_a        = slot_d.cart_type_a;
    assign media_n.cart_type_b        = slot_d.cart_type_b;
    assign media_n.mapper_a           = mapper_a;
    assign media_n.mapper_b           = mapper_b;
    assign media_n.sram_size_a        = sram_a;
    assign media_n.sram_size_b        = sram_b;
    assign media_n.sram_a_select_hide = sram_a_hide;
    assign media_n.sram_loadsave_hide = (sram_a == SRAM_SIZE_NONE) && (sram_b == SRAM_SIZE_NONE);
    assign media_n.rom_a_load_hide    = !slot_a_rom;
    assign media_n.rom_b_load_hide    = !slot_b_rom;
    // the MSX2 always carries its internal disk interface.
    assign media_n.fdc_enabled        = (slot_d.conf.typ == MSX2) ||
                                        (slot_d.cart_type_a == CART_TYPE_FDC);
    assign media_n.eject              = slot_d.eject;
    assign media_n.mapper_a_sel       = slot_d.mapper_a_sel;
    assign media_n.mapper_b_sel       = slot_d.mapper_b_sel;
    assign media_n.sram_a_sel         = slot_d.sram_a_sel;
    assign media_n.conf               = slot_d.conf;

    always_ff @(posedge clk) begin
        media_q <= media_n;
    end

endmodule

// ==== change_monitor.sv ====
`timescale 1ns/1ps

module change_monitor (
    input  logic                        clk,
    input  logic                        reset,
    input  msx_setup_pkg::media_stage_t media_d,
    output msx_setup_pkg::cart_type_t   cart_type_a,
    output msx_setup_pkg::cart_type_t   cart_type_b,
    output msx_setup_pkg::mapper_t      mapper_a,
    output msx_setup_pkg::mapper_t      mapper_b,
    output msx_setup_pkg::sram_size_t   sram_size_a,
    output msx_setup_pkg::sram_size_t   sram_size_b,
    output logic                        sram_a_select_hide,
    output logic                        sram_loadsave_hide,
    output logic                        rom_a_load_hide,
    output logic                        rom_b_load_hide,
    output logic                        fdc_enabled,
    output msx_setup_pkg::msx_config_t  msx_conf,
    output logic                        reset_request,
    output logic [1:0]                  cart_changed,
    output logic [1:0]                  rom_eject
);
    import msx_setup_pkg::*;

    // settings that only take effect after a machine reset.
    typedef struct packed {
        cart_type_t  cart_type_b;
        cart_type_t  cart_type_a;
        mapper_sel_t mapper_a_sel;
        mapper_sel_t mapper_b_sel;
        sram_size_t  sram_a_sel;
        ram_size_t   ram_size;
    } change_key_t;

    change_key_t key;
    change_key_t baseline;
    cart_type_t  prev_cart_a;
    cart_type_t  prev_cart_b;
    settle_cnt_t settle_cnt;
    logic        settled;
    logic        settle_done;
    logic [1:0]  eject_n;
    logic [1:0]  cart_diff;

    assign key.cart_type_b  = media_d.cart_type_b;
    assign key.cart_type_a  = media_d.cart_type_a;
    assign key.mapper_a_sel = media_d.mapper_a_sel;
    assign key.mapper_b_sel = media_d.mapper_b_sel;
    assign key.sram_a_sel   = media_d.sram_a_sel;
    assign key.ram_size     = media_d.conf.ram_size;

    assign settle_done = !settled && (settle_cnt == SETTLE_LAST);

    assign eject_n[0] = media_d.eject && (media_d.cart_type_a == CART_TYPE_ROM);
    assign eject_n[1] = media_d.eject && (media_d.cart_type_b == CART_TYPE_ROM);

    assign cart_diff[0] = (media_d.cart_type_a != prev_cart_a);
    assign cart_diff[1] = (media_d.cart_type_b != prev_cart_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            settle_cnt    <= '0;
            settled       <= 1'b0;
            reset_request <= 1'b0;
            cart_changed  <= 2'b00;
            rom_eject     <= 2'b00;
        end else begin
            if (!settled) begin
                settle_cnt <= settle_cnt + settle_cnt_t'(1);
            end
            if (settle_done) begin
                settled <= 1'b1;
            end
            reset_request <= settled && (key != baseline);
            cart_changed  <= settled ? cart_diff : 2'b00;
            rom_eject     <= eject_n;
        end
    end

    // the baseline is the key of the first input set taken after reset.
    always_ff @(posedge clk) begin
        if (settle_done && !reset) begin
            baseline <= key;
        end
        prev_cart_a <= media_d.cart_type_a;
        prev_cart_b <= media_d.cart_type_b;
    end

    always_ff @(posedge clk) begin
        cart_type_a        <= media_d.cart_type_a;
        cart_type_b        <= media_d.cart_type_b;
        mapper_a           <= media_d.mapper_a;
        mapper_b           <= media_d.mapper_b;
        sram_size_a        <= media_d.sram_size_a;
        sram_size_b        <= media_d.sram_size_b;
        sram_a_select_hide <= media_d.sram_a_select_hide;
        sram_loadsave_hide <= media_d.sram_loadsave_hide;
        rom_a_load_hide    <= media_d.rom_a_load_hide;
        rom_b_load_hide    <= media_d.rom_b_load_hide;
        fdc_enabled        <= media_d.fdc_enabled;
        msx_conf           <= media_d.conf;
    end

endmodule

// ==== msx_setup.sv ====
`timescale 1ns/1ps

module msx_setup (
    input  logic                       clk,
    input  logic                       reset,
    input  msx_setup_pkg::status_t     status,
    input  logic                       scandoubler,
    input  msx_setup_pkg::mapper_t     mapper_detected_a,
    input  msx_setup_pkg::mapper_t     mapper_detected_b,
    input  msx_setup_pkg::sram_size_t  sram_detected_a,
    input  msx_setup_pkg::sram_size_t  sram_detected_b,
    input  msx_setup_pkg::sdram_size_t sdram_size,
    output msx_setup_pkg::cart_type_t  cart_type_a,
    output msx_setup_pkg::cart_type_t  cart_type_b,
    output msx_setup_pkg::mapper_t     mapper_a,
    output msx_setup_pkg::mapper_t     mapper_b,
    output msx_setup_pkg::sram_size_t  sram_size_a,
    output msx_setup_pkg::sram_size_t  sram_size_b,
    output logic                       sram_a_select_hide,
    output logic                       sram_loadsave_hide,
    output logic                       rom_a_load_hide,
    output logic                       rom_b_load_hide,
    output logic                       fdc_enabled,
    output msx_setup_pkg::msx_config_t msx_conf,
    output logic                       reset_request,
    output logic [1:0]                 cart_changed,
    output logic [1:0]                 rom_eject
);
    import msx_setup_pkg::*;

    slot_stage_t  slot_w;
    media_stage_t media_w;

    slot_resolve u_slot_resolve (
        .clk               (clk),
        .reset             (reset),
        .status            (status),
        .scandoubler       (scandoubler),
        .mapper_detected_a (mapper_detected_a),
        .mapper_detected_b (mapper_detected_b),
        .sram_detected_a   (sram_detected_a),
        .sram_detected_b   (sram_detected_b),
        .sdram_size        (sdram_size),
        .slot_q            (slot_w)
    );

    media_resolve u_media_resolve (
        .clk     (clk),
        .slot_d  (slot_w),
        .media_q (media_w)
    );

    change_monitor u_change_monitor (
        .clk                (clk),
        .reset              (reset),
        .media_d            (media_w),
        .cart_type_a        (cart_type_a),
        .cart_type_b        (cart_type_b),
        .mapper_a           (mapper_a),
        .mapper_b           (mapper_b),
        .sram_size_a        (sram_size_a),
        .sram_size_b        (sram_size_b),
        .sram_a_select_hide (sram_a_select_hide),
        .sram_loadsave_hide (sram_loadsave_hide),
        .rom_a_load_hide    (rom_a_load_hide),
        .rom_b_load_hide    (rom_b_load_hide),
        .fdc_enabled        (fdc_enabled),
        .msx_conf           (msx_conf),
        .reset_request      (reset_request),
        .cart_changed       (cart_changed),
        .rom_eject          (rom_eject)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period, so the first rising edge comes at 2 ns.
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== msx_setup_properties.sv ====
`timescale 1ns/1ps

module msx_setup_properties (
    input logic                       clk,
    input logic                       reset,
    input msx_setup_pkg::cart_type_t  cart_type_a,
    input msx_setup_pkg::cart_type_t  cart_type_b,
    input msx_setup_pkg::sram_size_t  sram_size_a,
    input msx_setup_pkg::sram_size_t  sram_size_b,
    input logic                       sram_loadsave_hide,
    input logic                       reset_request,
    input logic [1:0]                 cart_changed,
    input logic [1:0]                 rom_eject
);
    import msx_setup_pkg::*;

    logic [2:0] fill_cnt;

    // the data registers hold no defined set until one has passed all stages.
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_cnt <= '0;
        end else if (fill_cnt != 3'(PIPE_DEPTH)) begin
            fill_cnt <= fill_cnt + 3'd1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (cart_changed == 2'b00) && !reset_request)
        else $error("cart_changed or reset_request high after a reset cycle");

    a_eject_a_rom: assert property (@(posedge clk) disable iff (fill_cnt != 3'(PIPE_DEPTH))
        rom_eject[0] |-> (cart_type_a == CART_TYPE_ROM))
        else $error("rom_eject[0] set while slot A holds no ROM");

    a_eject_b_rom: assert property (@(posedge clk) disable iff (fill_cnt != 3'(PIPE_DEPTH))
        rom_eject[1] |-> (cart_type_b == CART_TYPE_ROM))
        else $error("rom_eject[1] set while slot B holds no ROM");

    a_loadsave: assert property (@(posedge clk) disable iff (fill_cnt != 3'(PIPE_DEPTH))
        sram_loadsave_hide == ((sram_size_a == 3'd0) && (sram_size_b == 3'd0)))
        else $error("sram_loadsave_hide disagrees with the SRAM sizes");

endmodule

bind msx_setup msx_setup_properties props0 (
    .clk                (clk),
    .reset              (reset),
    .cart_type_a        (cart_type_a),
    .cart_type_b        (cart_type_b),
    .sram_size_a        (sram_size_a),
    .sram_size_b        (sram_size_b),
    .sram_loadsave_hide (sram_loadsave_hide),
    .reset_request      (reset_request),
    .cart_changed       (cart_changed),
    .rom_eject          (rom_eject)
);

// ==== msx_setup_tb.sv ====
`timescale 1ns/1ps

module msx_setup_tb;
    import msx_setup_pkg::*;

    typedef struct packed {
        status_t     status;
        logic        scandoubler;
        mapper_t     mapper_detected_a;
        mapper_t     mapper_detected_b;
        sram_size_t  sram_detected_a;
        sram_size_t  sram_detected_b;
        sdram_size_t sdram_size;
    } stim_t;

    typedef struct packed {
        logic        valid;
        logic [18:0] key;
        cart_type_t  cart_type_a;
        cart_type_t  cart_type_b;
        mapper_t     mapper_a;
        mapper_t     mapper_b;
        sram_size_t  sram_size_a;
        sram_size_t  sram_size_b;
        logic        sram_a_select_hide;
        logic        sram_loadsave_hide;
        logic        rom_a_load_hide;
        logic        rom_b_load_hide;
        logic        fdc_enabled;
        msx_config_t msx_conf;
        logic        reset_request;
        logic [1:0]  cart_changed;
        logic [1:0]  rom_eject;
    } expect_t;

    logic        clk;
    logic        reset;
    stim_t       cur;
    cart_type_t  cart_type_a;
    cart_type_t  cart_type_b;
    mapper_t     mapper_a;
    mapper_t     mapper_b;
    sram_size_t  sram_size_a;
    sram_size_t  sram_size_b;
    logic        sram_a_select_hide;
    logic        sram_loadsave_hide;
    logic        rom_a_load_hide;
    logic        rom_b_load_hide;
    logic        fdc_enabled;
    msx_config_t msx_conf;
    logic        reset_request;
    logic [1:0]  cart_changed;
    logic [1:0]  rom_eject;

    logic [31:0] lfsr_state = 32'h4e73;
    expect_t     hist [PIPE_DEPTH];
    int          checks_run = 0;

    tb_clock clk_gen (
        .clk (clk)
    );

    msx_setup dut0 (
        .clk                (clk),
        .reset              (reset),
        .status             (cur.status),
        .scandoubler        (cur.scandoubler),
        .mapper_detected_a  (cur.mapper_detected_a),
        .mapper_detected_b  (cur.mapper_detected_b),
        .sram_detected_a    (cur.sram_detected_a),
        .sram_detected_b    (cur.sram_detected_b),
        .sdram_size         (cur.sdram_size),
        .cart_type_a        (cart_type_a),
        .cart_type_b        (cart_type_b),
        .mapper_a           (mapper_a),
        .mapper_b           (mapper_b),
        .sram_size_a        (sram_size_a),
        .sram_size_b        (sram_size_b),
        .sram_a_select_hide (sram_a_select_hide),
        .sram_loadsave_hide (sram_loadsave_hide),
        .rom_a_load_hide    (rom_a_load_hide),
        .rom_b_load_hide    (rom_b_load_hide),
        .fdc_enabled        (fdc_enabled),
        .msx_conf           (msx_conf),
        .reset_request      (reset_request),
        .cart_changed       (cart_changed),
        .rom_eject          (rom_eject)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] draw_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic stim_t random_inputs();
        stim_t s;
        s.status            = draw_bits(64);
        s.scandoubler       = (draw_bits(1) != 0);
        s.mapper_detected_a = mapper_t'(draw_bits(6));
        s.mapper_detected_b = mapper_t'(draw_bits(6));
        s.sram_detected_a   = sram_size_t'(draw_bits(3));
        s.sram_detected_b   = sram_size_t'(draw_bits(3));
        s.sdram_size        = sdram_size_t'(draw_bits(2));
        return s;
    endfunction

    function automatic mapper_t resolve_mapper(input mapper_sel_t sel, input mapper_t detected);
        case (sel)
            4'd0:    return detected;
            4'd9:    return MAPPER_NO_UNKNOWN;
            default: return {2'b00, sel};
        endcase
    endfunction

    function automatic expect_t predict_outputs(input stim_t s);
        expect_t     e;
        cart_type_t  sel_a;
        mapper_sel_t map_a_sel;
        mapper_sel_t map_b_sel;
        sram_size_t  sram_sel;
        e         = '0;
        sel_a     = s.status[19:17];
        map_a_sel = s.status[23:20];
        map_b_sel = {1'b0, s.status[34:32]};
        sram_sel  = s.status[28:26];

        e.msx_conf.typ           = s.status[11];
        e.msx_conf.scandoubler   = s.scandoubler;
        e.msx_conf.cas_audio_src = s.status[8];
        e.msx_conf.border        = s.status[38];
        if (e.msx_conf.typ == MSX1) begin
            e.msx_conf.video_mode = s.status[12] ? 2'd2 : 2'd1;
        end else begin
            e.msx_conf.video_mode = s.status[14:13];
        end
        e.msx_conf.ram_size = (s.sdram_size == 2'd0) ? SIZE64 : s.status[16:15];

        case (sel_a)
            3'd0, 3'd1, 3'd2, 3'd3, 3'd4: e.cart_type_a = sel_a;
            3'd5:    e.cart_type_a = (e.msx_conf.typ == MSX1) ? CART_TYPE_FDC : CART_TYPE_EMPTY;
            default: e.cart_type_a = CART_TYPE_EMPTY;
        endcase
        e.cart_type_b = (s.status[31:29] < 3'd4) ? s.status[31:29] : CART_TYPE_EMPTY;

        e.mapper_a = resolve_mapper(map_a_sel, s.mapper_detected_a);
        e.mapper_b = resolve_mapper(map_b_sel, s.mapper_detected_b);
        e.sram_a_select_hide = (e.cart_type_a != CART_TYPE_ROM) || (map_a_sel == 4'd0);

        if (e.cart_type_a == CART_TYPE_FM_PAC || e.cart_type_a == CART_TYPE_GM2) begin
            e.sram_size_a = SRAM_SIZE_8K;
        end else if (sram_sel == 3'd7) begin
            e.sram_size_a = 3'd0;
        end else if (e.sram_a_select_hide || sram_sel == 3'd0) begin
            e.sram_size_a = s.sram_detected_a;
        end else begin
            e.sram_size_a = sram_sel;
        end
        e.sram_size_b = (e.cart_type_b == CART_TYPE_FM_PAC) ? SRAM_SIZE_8K : 3'd0;

        e.sram_loadsave_hide = (e.sram_size_a == 3'd0) && (e.sram_size_b == 3'd0);
        e.rom_a_load_hide    = (e.cart_type_a != CART_TYPE_ROM);
        e.rom_b_load_hide    = (e.cart_type_b != CART_TYPE_ROM);
        e.fdc_enabled        = (e.msx_conf.typ == MSX2) || (e.cart_type_a == CART_TYPE_FDC);
        e.rom_eject[0]       = s.status[10] && (e.cart_type_a == CART_TYPE_ROM);
        e.rom_eject[1]       = s.status[10] && (e.cart_type_b == CART_TYPE_ROM);
        e.key = {e.cart_type_b, e.cart_type_a, map_a_sel, map_b_sel, sram_sel,
                 e.msx_conf.ram_size};
        return e;
    endfunction

    task automatic cart_type_check(input string name, input cart_type_t exp,
                                   input cart_type_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0.1f ns: %s expected %0d got %0d",
                     $realtime, name, exp, act);
            $display("Test failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic mapper_check(input string name, input mapper_t exp, input mapper_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0.1f ns: %s expected %0d got %0d",
                     $realtime, name, exp, act);
            $display("Test failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic sram_size_check(input string name, input sram_size_t exp,
                                   input sram_size_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0.1f ns: %s expected %0d got %0d",
                     $realtime, name, exp, act);
            $display("Test failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic config_check(input string name, input msx_config_t exp,
                                input msx_config_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0.1f ns: %s expected %h got %h",
                     $realtime, name, exp, act);
            $display("Test failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic bit_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0.1f ns: %s expected %b got %b",
                     $realtime, name, exp, act);
            $display("Test failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic verify_outputs(input expect_t e);
        cart_type_check("cart_type_a", e.cart_type_a, cart_type_a);
        cart_type_check("cart_type_b", e.cart_type_b, cart_type_b);
        mapper_check("mapper_a", e.mapper_a, mapper_a);
        mapper_check("mapper_b", e.mapper_b, mapper_b);
        sram_size_check("sram_size_a", e.sram_size_a, sram_size_a);
        sram_size_check("sram_size_b", e.sram_size_b, sram_size_b);
        bit_check("sram_a_select_hide", e.sram_a_select_hide, sram_a_select_hide);
        bit_check("sram_loadsave_hide", e.sram_loadsave_hide, sram_loadsave_hide);
        bit_check("rom_a_load_hide", e.rom_a_load_hide, rom_a_load_hide);
        bit_check("rom_b_load_hide", e.rom_b_load_hide, rom_b_load_hide);
        bit_check("fdc_enabled", e.fdc_enabled, fdc_enabled);
        config_check("msx_conf", e.msx_conf, msx_conf);
        bit_check("reset_request", e.reset_request, reset_request);
        bit_check("cart_changed[0]", e.cart_changed[0], cart_changed[0]);
        bit_check("cart_changed[1]", e.cart_changed[1], cart_changed[1]);
        bit_check("rom_eject[0]", e.rom_eject[0], rom_eject[0]);
        bit_check("rom_eject[1]", e.rom_eject[1], rom_eject[1]);
    endtask

    task automatic drive_inputs(input stim_t s);
        @(posedge clk);
        #0.5;
        cur = s;
    endtask

    // outputs are stable at the falling edge; each set is due PIPE_DEPTH cycles after it entered.
    initial begin
        expect_t     nxt;
        logic [18:0] base_key;
        logic        have_base;
        cart_type_t  prev_a;
        cart_type_t  prev_b;
        have_base = 1'b0;
        base_key  = '0;
        prev_a    = '0;
        prev_b    = '0;
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            hist[i] = '0;
        end
        forever begin
            @(negedge clk);
            if (hist[PIPE_DEPTH-1].valid) begin
                verify_outputs(hist[PIPE_DEPTH-1]);
                checks_run++;
            end
            for (int i = PIPE_DEPTH - 1; i > 0; i--) begin
                hist[i] = hist[i-1];
            end
            nxt = predict_outputs(cur);
            nxt.valid = !reset;
            if (nxt.valid) begin
                // the first set after reset is the one the baseline is taken from.
                if (!have_base) begin
                    base_key  = nxt.key;
                    have_base = 1'b1;
                end else begin
                    nxt.cart_changed = {nxt.cart_type_b != prev_b, nxt.cart_type_a != prev_a};
                end
                nxt.reset_request = (nxt.key != base_key);
                prev_a = nxt.cart_type_a;
                prev_b = nxt.cart_type_b;
            end
            hist[0] = nxt;
        end
    end

    initial begin
        int limit;
        int cycle_count;
        limit = 2 + 128 + 128 + 64 + 16 + 10 + 16 + PIPE_DEPTH + 1 + 20;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Test failed");
        $fatal(1, "timeout, the stimulus did not finish within %0d cycles", limit);
    end

    initial begin
        stim_t base;
        stim_t s;
        stim_t chg;
        reset = 1'b1;
        cur   = '0;
        base  = random_inputs();
        base.status[19:17] = 3'd0;
        base.status[31:29] = 3'd0;
        @(posedge clk);
        @(posedge clk);
        #0.5;
        reset = 1'b0;
        cur   = base;

        for (int t = 0; t < 2; t++) begin
            for (int a = 0; a < 8; a++) begin
                for (int b = 0; b < 8; b++) begin
                    s = random_inputs();
                    s.status[11]    = (t != 0);
                    s.status[19:17] = 3'(a);
                    s.status[31:29] = 3'(b);
                    drive_inputs(s);
                end
            end
        end

        for (int m = 0; m < 16; m++) begin
            for (int r = 0; r < 8; r++) begin
                s = random_inputs();
                s.status[23:20] = 4'(m);
                s.status[28:26] = 3'(r);
                s.status[34:32] = 3'(m + r);
                if (draw_bits(2) != 0) begin
                    s.status[19:17] = 3'd0;
                end
                drive_inputs(s);
            end
        end

        for (int i = 0; i < 64; i++) begin
            s = random_inputs();
            s.sdram_size = sdram_size_t'(i);
            drive_inputs(s);
        end

        // a mapper A change must raise reset_request and its undo must clear it.
        chg = base;
        chg.status[23:20] = base.status[23:20] + 4'd1;
        repeat (4) drive_inputs(base);
        repeat (6) drive_inputs(chg);
        repeat (6) drive_inputs(base);

        chg = base;
        chg.status[31:29] = 3'd1;
        repeat (4) drive_inputs(base);
        repeat (6) drive_inputs(chg);

        for (int i = 0; i < 16; i++) begin
            s = random_inputs();
            s.status[10]    = 1'b1;
            s.status[19:17] = 3'(i);
            s.status[31:29] = 3'(i / 2);
            drive_inputs(s);
        end

        repeat (PIPE_DEPTH + 1) @(posedge clk);
        if (checks_run > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "no output set reached the comparison point");
        end
    end

endmodule

// ==== msx_setup.f ====
msx_setup_pkg.sv
slot_resolve.sv
media_resolve.sv
change_monitor.sv
msx_setup.sv
tb_clock.sv
msx_setup_properties.sv
msx_setup_tb.sv

// ==== Makefile ====
TOP := msx_setup_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f msx_setup.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f msx_setup.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
